// ==== hw/adpcma_params.svh ====
// ADPCM-A address engine constants
`ifndef ADPCMA_PARAMS_SVH
`define ADPCMA_PARAMS_SVH

// One time slot per channel
`define ADPCMA_SLOTS    6
`define ADPCMA_CEN_DIV  4   // clk cycles per sample enable, short for simulation

// Nibble address is a page plus a nibble offset within the page
`define ADPCMA_PAGE_W   12
`define ADPCMA_OFS_W    9
`define ADPCMA_ADDR_W   21

`define ADPCMA_BANK_W   4
`define ADPCMA_ROM_W    24  // Bank on top of the byte address

`endif

// ==== hw/adpcma_pkg.sv ====
// ADPCM-A shared types
`include "adpcma_params.svh"

package adpcma_pkg;

    typedef logic [`ADPCMA_SLOTS-1:0]  slot_mask_t;  // One bit per channel
    typedef logic [2:0]                slot_idx_t;
    typedef logic [`ADPCMA_PAGE_W-1:0] page_t;
    typedef logic [`ADPCMA_BANK_W-1:0] bank_t;
    typedef logic [`ADPCMA_ADDR_W-1:0] nib_addr_t;
    typedef logic [`ADPCMA_ROM_W-1:0]  rom_addr_t;   // {bank, nibble address 20:1}

    // Channel number of a one-hot slot mask
    function automatic slot_idx_t slot_enc(slot_mask_t m);
        slot_idx_t idx;
        idx = '0;
        for (int i = 0; i < `ADPCMA_SLOTS; i++) begin
            if (m[i])
                idx = slot_idx_t'(i);
        end
        return idx;
    endfunction

    // Channel number to one-hot, out of range gives zero
    function automatic slot_mask_t slot_dec(slot_idx_t idx);
        return slot_mask_t'(1) << idx;
    endfunction

endpackage

// ==== hw/adpcma_rd_if.sv ====
// Pipeline read request
`timescale 1ns/1ps
`include "adpcma_params.svh"

interface adpcma_rd_if;
    import adpcma_pkg::*;

    logic [`ADPCMA_ADDR_W-2:0] addr;     // Byte address within the bank
    bank_t                     bank;
    logic                      sel;      // Low nibble when set
    logic                      rd;
    logic                      restart;  // Section begins anew
    slot_idx_t                 ch;

    // Counter side
    modport source (
        output addr, bank, sel, rd, restart, ch
    );

    // Fetch side only listens
    modport sink (
        input addr, bank, sel, rd, restart, ch
    );

endinterface

// ==== hw/adpcma_slot_seq.sv ====
// Sample enable and slot rotation
`timescale 1ns/1ps
`include "adpcma_params.svh"

module adpcma_slot_seq (
    input  logic                   clk,
    input  logic                   rst_n,
    output logic                   cen,
    output adpcma_pkg::slot_mask_t cur_ch,
    output adpcma_pkg::slot_mask_t en_ch
);
    import adpcma_pkg::*;

    localparam int DIV_W = $clog2(`ADPCMA_CEN_DIV);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`ADPCMA_CEN_DIV - 1);
    localparam slot_mask_t FIRST_SLOT = slot_mask_t'(1);

    logic [DIV_W-1:0] div_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
            cen     <= 1'b0;
            cur_ch  <= FIRST_SLOT;
        end else begin
            div_cnt <= (div_cnt == DIV_LAST) ? '0 : div_cnt + 1'b1;
            cen     <= (div_cnt == DIV_LAST);   // One clk wide
            if (cen)
                cur_ch <= {cur_ch[`ADPCMA_SLOTS-2:0], cur_ch[`ADPCMA_SLOTS-1]};
        end
    end

    // Slot two positions ahead, sits in pipeline stage 5
    assign en_ch = {cur_ch[`ADPCMA_SLOTS-3:0], cur_ch[`ADPCMA_SLOTS-1:`ADPCMA_SLOTS-2]};

    a_cur_onehot: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot(cur_ch)
    ) else $error("cur_ch lost its one-hot position");

endmodule

// ==== hw/adpcma_regs.sv ====
// CPU register port
`timescale 1ns/1ps
`include "adpcma_params.svh"

module adpcma_regs (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   cen,
    input  adpcma_pkg::slot_mask_t cur_ch,
    input  logic                   cpu_we,
    input  logic [7:0]             cpu_addr,
    input  logic [7:0]             cpu_din,
    output logic [15:0]            addr_in,
    output adpcma_pkg::slot_idx_t  addr_ch,
    output logic                   up_start,
    output logic                   up_end,
    output logic                   aon,
    output logic                   aoff,
    output adpcma_pkg::slot_mask_t clr_flags
);
    import adpcma_pkg::*;

    logic [7:0]  lo_start  [`ADPCMA_SLOTS];
    logic [7:0]  lo_end    [`ADPCMA_SLOTS];
    logic [15:0] val_start [`ADPCMA_SLOTS];
    logic [15:0] val_end   [`ADPCMA_SLOTS];

    slot_mask_t pend_start, pend_end, pend_on, pend_off;
    slot_mask_t take_start, take_end, take_on, take_off;
    slot_mask_t nxt_ch, wr_mask, key_mask;
    slot_idx_t  nxt_idx, wr_ch;
    logic       ch_ok, wr_start, wr_end, wr_hi, wr_key, wr_clr;

    assign wr_ch    = slot_idx_t'(cpu_addr[2:0]);
    assign ch_ok    = (wr_ch < `ADPCMA_SLOTS);
    assign wr_hi    = cpu_addr[3];
    assign wr_start = cpu_we && ch_ok && (cpu_addr[7:4] == 4'h1);
    assign wr_end   = cpu_we && ch_ok && (cpu_addr[7:4] == 4'h2);
    assign wr_key   = cpu_we && (cpu_addr == 8'h00);
    assign wr_clr   = cpu_we && (cpu_addr == 8'h30);
    assign wr_mask  = wr_hi ? slot_dec(wr_ch) : '0;
    assign key_mask = wr_key ? cpu_din[`ADPCMA_SLOTS-1:0] : '0;

    // Slot that reaches the pipeline input on the next enable
    assign nxt_ch  = {cur_ch[`ADPCMA_SLOTS-2:0], cur_ch[`ADPCMA_SLOTS-1]};
    assign nxt_idx = slot_enc(nxt_ch);

    // Start goes first, end waits one frame if both pending
    assign take_start = cen ? (nxt_ch & pend_start) : '0;
    assign take_end   = (cen && !(|take_start)) ? (nxt_ch & pend_end) : '0;
    assign take_on    = cen ? (nxt_ch & pend_on) : '0;
    assign take_off   = cen ? (nxt_ch & pend_off) : '0;

    always_ff @(posedge clk) begin
        if (wr_start && !wr_hi)
            lo_start[wr_ch] <= cpu_din;
        if (wr_start && wr_hi)
            val_start[wr_ch] <= {cpu_din, lo_start[wr_ch]};
        if (wr_end && !wr_hi)
            lo_end[wr_ch] <= cpu_din;
        if (wr_end && wr_hi)
            val_end[wr_ch] <= {cpu_din, lo_end[wr_ch]};
        if (|take_start || |take_end) begin
            addr_in <= (|take_start) ? val_start[nxt_idx] : val_end[nxt_idx];
            addr_ch <= nxt_idx;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_start <= '0;
            pend_end   <= '0;
            pend_on    <= '0;
            pend_off   <= '0;
            up_start   <= 1'b0;
            up_end     <= 1'b0;
            aon        <= 1'b0;
            aoff       <= 1'b0;
            clr_flags  <= '0;
        end else begin
            pend_start <= (pend_start & ~take_start) | (wr_start ? wr_mask : '0);
            pend_end   <= (pend_end & ~take_end) | (wr_end ? wr_mask : '0);
            // Latest key command on a channel wins
            pend_on  <= (pend_on & ~take_on & ~(cpu_din[7] ? key_mask : '0))
                        | (cpu_din[7] ? '0 : key_mask);
            pend_off <= (pend_off & ~take_off & ~(cpu_din[7] ? '0 : key_mask))
                        | (cpu_din[7] ? key_mask : '0);
            if (cen) begin
                up_start <= |take_start;
                up_end   <= |take_end;
                aon      <= |take_on;
                aoff     <= |take_off;
            end
            clr_flags <= wr_clr ? cpu_din[`ADPCMA_SLOTS-1:0] : '0;
        end
    end

    a_key_excl: assert property (
        @(posedge clk) disable iff (!rst_n) !(aon && aoff)
    ) else $error("key-on and key-off issued in the same slot");

endmodule

// ==== hw/adpcma_addr_cnt.sv ====
// Multiplexed sample address counter
`timescale 1ns/1ps
`include "adpcma_params.svh"

module adpcma_addr_cnt (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   cen,
    input  adpcma_pkg::slot_mask_t cur_ch,
    input  adpcma_pkg::slot_mask_t en_ch,
    input  logic [15:0]            addr_in,
    input  adpcma_pkg::slot_idx_t  addr_ch,
    input  logic                   up_start,
    input  logic                   up_end,
    input  logic                   aon,
    input  logic                   aoff,
    input  adpcma_pkg::slot_mask_t clr_flags,
    adpcma_rd_if.source            rd_src,
    output adpcma_pkg::slot_mask_t flags
);
    import adpcma_pkg::*;

    localparam int AW = `ADPCMA_ADDR_W;
    localparam int OW = `ADPCMA_OFS_W;

    // Per-channel state carried around the ring
    typedef struct packed {
        nib_addr_t addr;
        page_t     start_pg;
        page_t     end_pg;
        bank_t     bank;
        logic      on;
        logic      done;
        logic      clr;    // Restart pending for this pass
        logic      skip;   // Hold the address once after a restart
    } entry_t;

    localparam entry_t ENTRY_RST = '{
        addr: '0, start_pg: '0, end_pg: '0, bank: '0,
        on: 1'b0, done: 1'b1, clr: 1'b0, skip: 1'b0
    };

    entry_t     st [1:`ADPCMA_SLOTS];
    entry_t     in1, in2, in5;
    logic       up1, load6, sum5, sum6, rd1;
    slot_idx_t  ch6, ch1;
    slot_mask_t done_frame, last_done, rise;

    assign up1   = (cur_ch == slot_dec(addr_ch));   // CPU update targets stage 1
    assign load6 = st[6].clr && st[6].on;
    assign sum5  = st[5].on && !st[5].done;

    always_comb begin
        // Stage 1 to 2 takes key commands and address updates
        in2 = st[1];
        in2.on  = aoff ? 1'b0 : (aon | (st[1].on & ~st[1].done));
        in2.clr = aon | aoff | st[1].done;
        if (up_start && up1) begin
            in2.start_pg = page_t'(addr_in);
            in2.bank     = addr_in[15:12];
        end
        if (up_end && up1)
            in2.end_pg = page_t'(addr_in);

        // End compare in stage 4, ignored while a restart is in flight
        in5 = st[4];
        in5.done = (st[4].addr[AW-1:OW] == st[4].end_pg) && (&st[4].addr[OW-1:0])
                   && !(st[4].clr && st[4].on);

        // Stage 6 back to 1 either loads the start or steps one nibble
        in1 = st[6];
        if (load6)
            in1.addr = {st[6].start_pg, {OW{1'b0}}};
        else if (sum6 && !st[6].skip)
            in1.addr = st[6].addr + 1'b1;
        in1.skip = load6 ? 1'b1 : (sum6 ? 1'b0 : st[6].skip);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 1; k <= `ADPCMA_SLOTS; k++)
                st[k] <= ENTRY_RST;
            sum6 <= 1'b0;
            rd1  <= 1'b0;
            ch6  <= 3'd1;   // Stage 6 trails stage 1 by five slots
            ch1  <= 3'd0;
        end else if (cen) begin
            st[1] <= in1;
            st[2] <= in2;
            st[3] <= st[2];
            st[4] <= st[3];
            st[5] <= in5;
            st[6] <= st[5];
            sum6  <= sum5;
            rd1   <= sum6;
            ch6   <= slot_enc(en_ch);   // en_ch names the stage 5 slot
            ch1   <= ch6;
        end
    end

    assign rd_src.addr    = st[1].addr[AW-1:1];
    assign rd_src.sel     = st[1].addr[0];
    assign rd_src.bank    = st[1].bank;
    assign rd_src.rd      = rd1;
    assign rd_src.restart = st[1].clr;
    assign rd_src.ch      = ch1;

    // Done bits sampled per frame, flags set on a rising done
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_frame <= '1;
            last_done  <= '1;
            rise       <= '0;
            flags      <= '0;
        end else begin
            if (cen)
                done_frame[ch1] <= st[1].done;
            if (cen && cur_ch[0])
                last_done <= done_frame;
            rise  <= (cen && cur_ch[0]) ? (done_frame & ~last_done) : '0;
            flags <= (flags | rise) & ~clr_flags;
        end
    end

    // A channel that finished last pass reads again only after a key-on
    a_no_rd_done: assert property (
        @(posedge clk) disable iff (!rst_n)
        cen && sum6 && !load6 |-> !done_frame[ch6]
    ) else $error("read issued for finished channel %0d", ch6);

endmodule

// ==== hw/adpcma_fetch.sv ====
// ROM read and nibble select
`timescale 1ns/1ps

module adpcma_fetch (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cen,
    adpcma_rd_if.sink             rd_snk,
    input  logic [7:0]            rom_data,
    output adpcma_pkg::rom_addr_t rom_addr,
    output logic                  rom_oe_n,
    output logic                  smp_valid,
    output adpcma_pkg::slot_idx_t smp_ch,
    output logic [3:0]            smp_nib,
    output logic                  smp_restart
);
    import adpcma_pkg::*;

    // Read in flight, answered by the next enable
    logic      pend_rd;
    logic      pend_sel;
    logic      pend_restart;
    slot_idx_t pend_ch;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rom_addr    <= '0;
            rom_oe_n    <= 1'b1;
            pend_rd     <= 1'b0;
            smp_valid   <= 1'b0;
            smp_restart <= 1'b0;
        end else begin
            smp_valid <= cen && pend_rd;   // One clk per sample
            if (cen) begin
                rom_oe_n <= !rd_snk.rd;
                pend_rd  <= rd_snk.rd;
                if (rd_snk.rd)
                    rom_addr <= {rd_snk.bank, rd_snk.addr};
                if (pend_rd)
                    smp_restart <= pend_restart;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cen) begin
            pend_ch      <= rd_snk.ch;
            pend_sel     <= rd_snk.sel;
            pend_restart <= rd_snk.restart;
            if (pend_rd) begin
                smp_ch  <= pend_ch;
                smp_nib <= pend_sel ? rom_data[3:0] : rom_data[7:4];  // Even nibble is high
            end
        end
    end

endmodule

// ==== hw/adpcma_top.sv ====
// ADPCM-A sample address engine
`timescale 1ns/1ps

module adpcma_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cpu_we,
    input  logic [7:0]  cpu_addr,
    input  logic [7:0]  cpu_din,
    output logic [23:0] rom_addr,
    output logic        rom_oe_n,
    input  logic [7:0]  rom_data,
    output logic        smp_valid,
    output logic [2:0]  smp_ch,
    output logic [3:0]  smp_nib,
    output logic        smp_restart,
    output logic [5:0]  flags
);
    import adpcma_pkg::*;

    logic        cen;
    slot_mask_t  cur_ch, en_ch, clr_flags;
    logic [15:0] addr_in;
    slot_idx_t   addr_ch;
    logic        up_start, up_end, aon, aoff;

    adpcma_rd_if rd_bus ();

    adpcma_slot_seq i_slot_seq (
        .clk    (clk),
        .rst_n  (rst_n),
        .cen    (cen),
        .cur_ch (cur_ch),
        .en_ch  (en_ch)
    );

    adpcma_regs i_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .cen       (cen),
        .cur_ch    (cur_ch),
        .cpu_we    (cpu_we),
        .cpu_addr  (cpu_addr),
        .cpu_din   (cpu_din),
        .addr_in   (addr_in),
        .addr_ch   (addr_ch),
        .up_start  (up_start),
        .up_end    (up_end),
        .aon       (aon),
        .aoff      (aoff),
        .clr_flags (clr_flags)
    );

    adpcma_addr_cnt i_addr_cnt (
        .clk       (clk),
        .rst_n     (rst_n),
        .cen       (cen),
        .cur_ch    (cur_ch),
        .en_ch     (en_ch),
        .addr_in   (addr_in),
        .addr_ch   (addr_ch),
        .up_start  (up_start),
        .up_end    (up_end),
        .aon       (aon),
        .aoff      (aoff),
        .clr_flags (clr_flags),
        .rd_src    (rd_bus),
        .flags     (flags)
    );

    adpcma_fetch i_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .cen         (cen),
        .rd_snk      (rd_bus),
        .rom_data    (rom_data),
        .rom_addr    (rom_addr),
        .rom_oe_n    (rom_oe_n),
        .smp_valid   (smp_valid),
        .smp_ch      (smp_ch),
        .smp_nib     (smp_nib),
        .smp_restart (smp_restart)
    );

endmodule

// ==== verification/adpcma_checker.sv ====
// Reference model and scoreboard
`timescale 1ns/1ps

module adpcma_checker (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cpu_we,
    input  logic [7:0]  cpu_addr,
    input  logic [7:0]  cpu_din,
    input  logic [23:0] rom_addr,
    input  logic        rom_oe_n,
    input  logic        smp_valid,
    input  logic [2:0]  smp_ch,
    input  logic [3:0]  smp_nib,
    input  logic        smp_restart,
    input  logic [5:0]  flags,
    output int          err_cnt,
    output int          chk_cnt
);
    localparam int LIMIT = 120;   // clk cycles allowed without progress

    logic [7:0]  lo_s [6];
    logic [7:0]  lo_e [6];
    logic [15:0] val_s [6];
    logic [15:0] val_e [6];
    logic [20:0] cur [6];         // Next nibble expected
    logic [20:0] last [6];
    logic [3:0]  bank [6];
    logic [5:0]  on, first, skip, wait_flag, mflag;
    int          grace [6];       // Samples still allowed after a key-off
    int          clr_lag [6];
    int          age [6];
    logic [23:0] prev_addr;
    logic        prev_oe_n;

    function automatic logic [7:0] rom_byte(input logic [23:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16];
    endfunction

    task automatic compare_val(input string name, input int c, input logic [23:0] exp,
                               input logic [23:0] got);
        chk_cnt++;
        if (exp !== got) begin
            $display("[FAIL] %s ch %0d exp %h got %h", name, c, exp, got);
            err_cnt++;
        end
    endtask

    task automatic observe_cpu();
        int c;
        c = int'(cpu_addr[2:0]);
        if (cpu_we && c < 6) begin
            case (cpu_addr[7:3])
                5'h02: lo_s[c] = cpu_din;
                5'h03: val_s[c] = {cpu_din, lo_s[c]};   // High byte commits
                5'h04: lo_e[c] = cpu_din;
                5'h05: val_e[c] = {cpu_din, lo_e[c]};
                default: ;
            endcase
        end
        for (int k = 0; k < 6; k++) begin
            if (cpu_we && cpu_addr == 8'h00 && cpu_din[k] && !cpu_din[7]) begin
                on[k] = 1'b1;
                first[k] = 1'b1;
                skip[k] = 1'b1;           // Start nibble comes twice
                grace[k] = 0;
                wait_flag[k] = 1'b0;
                age[k] = 0;
                cur[k] = {val_s[k][11:0], 9'h000};
                last[k] = {val_e[k][11:0], 9'h1ff};
                bank[k] = val_s[k][15:12];
            end
            if (cpu_we && cpu_addr == 8'h00 && cpu_din[k] && cpu_din[7] && on[k]) begin
                on[k] = 1'b0;
                grace[k] = 2;             // Reads already in flight may still land
                age[k] = 0;
            end
            if (cpu_we && cpu_addr == 8'h30 && cpu_din[k]) begin
                mflag[k] = 1'b0;
                clr_lag[k] = 4;
            end
        end
    endtask

    task automatic check_sample();
        logic [23:0] exp_addr;
        logic [7:0]  b;
        int          c;
        c = int'(smp_ch);
        if (c >= 6 || !(on[c] || grace[c] > 0)) begin
            $display("[FAIL] smp_ch %h got a sample while the channel is stopped", smp_ch);
            err_cnt++;
            return;
        end
        exp_addr = {bank[c], cur[c][20:1]};
        b = rom_byte(exp_addr);
        compare_val("rom_oe_n", c, 24'h0, {23'h0, prev_oe_n});
        compare_val("rom_addr", c, exp_addr, prev_addr);
        compare_val("smp_nib", c, {20'h0, cur[c][0] ? b[3:0] : b[7:4]}, {20'h0, smp_nib});
        compare_val("smp_restart", c, {23'h0, first[c]}, {23'h0, smp_restart});
        first[c] = 1'b0;
        age[c] = 0;
        if (grace[c] > 0)
            grace[c]--;
        if (skip[c])
            skip[c] = 1'b0;
        else if (cur[c] == last[c]) begin
            on[c] = 1'b0;
            wait_flag[c] = 1'b1;
        end else
            cur[c] = cur[c] + 21'd1;
    endtask

    task automatic check_channels();
        for (int k = 0; k < 6; k++) begin
            if (clr_lag[k] > 0)
                clr_lag[k]--;
            if (flags[k] && !mflag[k] && wait_flag[k]) begin
                mflag[k] = 1'b1;
                wait_flag[k] = 1'b0;
            end else if (flags[k] !== mflag[k] && clr_lag[k] == 0) begin
                $display("[FAIL] flags[%0d] exp %h got %h", k, mflag[k], flags[k]);
                err_cnt++;
                mflag[k] = flags[k];
            end
            age[k]++;
            if ((on[k] || wait_flag[k]) && age[k] > LIMIT) begin
                $display("timeout: channel %0d %s", k,
                         on[k] ? "sent no sample in time" : "never raised its flag");
                err_cnt++;
                age[k] = 0;
                wait_flag[k] = 1'b0;
            end
            if (grace[k] > 0 && age[k] > LIMIT)
                grace[k] = 0;
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!rst_n) begin
            on = '0;
            first = '0;
            skip = '0;
            wait_flag = '0;
            mflag = '0;
            err_cnt = 0;
            chk_cnt = 0;
            prev_oe_n = 1'b1;
            prev_addr = '0;
            for (int k = 0; k < 6; k++) begin
                grace[k] = 0;
                clr_lag[k] = 0;
                age[k] = 0;
            end
        end else begin
            observe_cpu();
            if (smp_valid)
                check_sample();
            check_channels();
            prev_addr = rom_addr;   // Read that the next sample answers
            prev_oe_n = rom_oe_n;
        end
    end

endmodule

// ==== verification/tb_adpcma_top.sv ====
// ADPCM-A address engine testbench
`timescale 1ns/1ps
`include "adpcma_params.svh"

module tb_adpcma_top;
    localparam int NROWS = 7;
    localparam int MAXWR = 10;
    localparam int FRAME = `ADPCMA_SLOTS * `ADPCMA_CEN_DIV;  // clk cycles per frame

    logic        clk, rst_n, cpu_we;
    logic [7:0]  cpu_addr, cpu_din, rom_data;
    logic [23:0] rom_addr;
    logic        rom_oe_n, smp_valid, smp_restart;
    logic [2:0]  smp_ch;
    logic [3:0]  smp_nib;
    logic [5:0]  flags;
    int          err_cnt, chk_cnt, tb_errs, seed;
    logic [11:0] pg [4];

    // Stimulus table, one row per test
    string      row_name   [NROWS];
    int         row_nwr    [NROWS];
    logic [7:0] wr_addr    [NROWS][MAXWR];
    logic [7:0] wr_data    [NROWS][MAXWR];
    int         row_frames [NROWS];
    logic [5:0] row_flags  [NROWS];   // Flags that must be up when the row ends

    // ROM folds all address bytes, the checker uses the same rule
    assign rom_data = rom_oe_n ? 8'hff : (rom_addr[7:0] ^ rom_addr[15:8] ^ rom_addr[23:16]);

    adpcma_top i_adpcma_top (
        .clk(clk), .rst_n(rst_n), .cpu_we(cpu_we), .cpu_addr(cpu_addr), .cpu_din(cpu_din),
        .rom_addr(rom_addr), .rom_oe_n(rom_oe_n), .rom_data(rom_data),
        .smp_valid(smp_valid), .smp_ch(smp_ch), .smp_nib(smp_nib),
        .smp_restart(smp_restart), .flags(flags)
    );

    adpcma_checker i_checker (
        .clk(clk), .rst_n(rst_n), .cpu_we(cpu_we), .cpu_addr(cpu_addr), .cpu_din(cpu_din),
        .rom_addr(rom_addr), .rom_oe_n(rom_oe_n), .smp_valid(smp_valid), .smp_ch(smp_ch),
        .smp_nib(smp_nib), .smp_restart(smp_restart), .flags(flags),
        .err_cnt(err_cnt), .chk_cnt(chk_cnt)
    );

    task automatic set_row(input int r, input string name, input int frames,
                           input logic [5:0] fl);
        row_name[r]   = name;
        row_frames[r] = frames;
        row_flags[r]  = fl;
        row_nwr[r]    = 0;
    endtask

    task automatic add_write(input int r, input logic [7:0] a, input logic [7:0] d);
        wr_addr[r][row_nwr[r]] = a;
        wr_data[r][row_nwr[r]] = d;
        row_nwr[r]++;
    endtask

    // Start and end pages of one channel, high bytes last
    task automatic add_channel(input int r, input logic [2:0] ch, input logic [3:0] bank,
                               input logic [11:0] sp, input logic [11:0] ep);
        add_write(r, 8'h10 + ch, sp[7:0]);
        add_write(r, 8'h18 + ch, {bank, sp[11:8]});
        add_write(r, 8'h20 + ch, ep[7:0]);
        add_write(r, 8'h28 + ch, {4'h0, ep[11:8]});
    endtask

    task automatic build_table();
        set_row(0, "single channel key-on", 12, 6'h00);
        add_channel(0, 3'd0, 4'h3, pg[0], pg[0]);          // One page only
        add_write(0, 8'h00, 8'h01);
        set_row(1, "two channels interleaved", 12, 6'h00);
        add_channel(1, 3'd1, 4'h5, pg[1], pg[1] + 12'd2);
        add_channel(1, 3'd2, 4'ha, pg[2], pg[2] + 12'd2);
        add_write(1, 8'h00, 8'h06);
        set_row(2, "end of sample and flag", 480, 6'h01);
        set_row(3, "clear of other flags", 2, 6'h01);
        add_write(3, 8'h30, 8'h3e);
        set_row(4, "clear of the finished flag", 2, 6'h00);
        add_write(4, 8'h30, 8'h01);
        set_row(5, "key-off mid-sample", 12, 6'h00);
        add_write(5, 8'h00, 8'h82);
        set_row(6, "bank bits on a new channel", 12, 6'h00);
        add_channel(6, 3'd3, 4'hc, pg[3], pg[3] + 12'd1);
        add_write(6, 8'h00, 8'h08);
    endtask

    task automatic cpu_write(input logic [7:0] a, input logic [7:0] d);
        cpu_we   = 1'b1;
        cpu_addr = a;
        cpu_din  = d;
        @(posedge clk);
        #2 cpu_we = 1'b0;
    endtask

    task automatic wait_flags(input logic [5:0] mask);
        int n;
        n = 0;
        while ((flags & mask) != mask && n < 120 * FRAME) begin
            @(posedge clk);
            #2;
            n++;
        end
        if ((flags & mask) != mask) begin
            $display("timeout: flags %h never reached mask %h", flags, mask);
            tb_errs++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        rst_n    = 1'b0;
        cpu_we   = 1'b0;
        cpu_addr = 8'h00;
        cpu_din  = 8'h00;
        tb_errs  = 0;
        seed     = 32'h9fe2e2e8;
        for (int i = 0; i < 4; i++)
            pg[i] = 12'($random(seed)) & 12'h7ff;   // Keeps end pages from wrapping
        build_table();
        repeat (2) @(posedge clk);
        #2 rst_n = 1'b1;
        repeat (4 * FRAME) @(posedge clk);
        #2;
        for (int r = 0; r < NROWS; r++) begin
            for (int k = 0; k < row_nwr[r]; k++)
                cpu_write(wr_addr[r][k], wr_data[r][k]);
            repeat (row_frames[r] * FRAME) @(posedge clk);
            #2;
            wait_flags(row_flags[r]);
            $display("test %0d %s finished, errors so far %0d", r, row_name[r],
                     err_cnt + tb_errs);
        end
        $display("checks %0d, errors %0d", chk_cnt, err_cnt + tb_errs);
        if (err_cnt + tb_errs == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+hw
hw/adpcma_pkg.sv
hw/adpcma_rd_if.sv
hw/adpcma_slot_seq.sv
hw/adpcma_regs.sv
hw/adpcma_addr_cnt.sv
hw/adpcma_fetch.sv
hw/adpcma_top.sv
verification/adpcma_checker.sv
verification/tb_adpcma_top.sv

// ==== Makefile ====
# Verilator build of the ADPCM-A address engine testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f list.f \
		--top-module tb_adpcma_top -Mdir obj_dir -o sim_adpcma

run: compile
	./obj_dir/sim_adpcma | tee sim.log
	grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log
